// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only -Wall --timing
TOP       ?= tb_top
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TEST PASSED"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// File: hdl/debug_req_gen.sv
`timescale 1ns/1ps

module debug_req_gen (
    input  logic       clk_i,
    input  logic       rst_ni,
    periph_wr_if.debug wr,
    output logic       debug_req_o
);

    localparam int DLY_W = mm_periph_pkg::DBG_DELAY_W;
    localparam int DUR_W = mm_periph_pkg::DBG_DUR_W;

    logic [mm_periph_pkg::DATA_W-1:0] ctrl;
    logic                             ctrl_value;
    logic                             ctrl_pulse;
    logic [DLY_W-1:0]                 ctrl_delay;
    logic [DUR_W-1:0]                 ctrl_dur;
    logic                             accept;
    logic [DLY_W-1:0]                 delay_cnt_q;
    logic [DUR_W-1:0]                 dur_cnt_q;
    logic                             value_q;

    // --------------------------------------------------
    // control word fields
    // --------------------------------------------------

    assign ctrl       = wr.wdata;
    assign ctrl_value = ctrl[mm_periph_pkg::DBG_VALUE_BIT];
    assign ctrl_pulse = ctrl[mm_periph_pkg::DBG_PULSE_BIT];
    assign ctrl_delay = ctrl[mm_periph_pkg::DBG_DELAY_LSB +: DLY_W];
    assign ctrl_dur   = ctrl[mm_periph_pkg::DBG_DUR_LSB +: DUR_W];

    // busy while either counter runs, new commands are dropped
    assign accept = wr.debug_we && (delay_cnt_q == '0) && (dur_cnt_q == '0);

    always_ff @(posedge clk_i) begin
        if (accept) begin
            value_q <= ctrl_value;
        end
    end

    // --------------------------------------------------
    // delay then optional pulse
    // --------------------------------------------------

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            delay_cnt_q <= '0;
            dur_cnt_q   <= '0;
            debug_req_o <= 1'b0;
        end else if (accept) begin
            // zero delay or width acts as one
            delay_cnt_q <= (ctrl_delay == '0) ? DLY_W'(1) : ctrl_delay;
            if (ctrl_pulse) begin
                dur_cnt_q <= (ctrl_dur == '0) ? DUR_W'(1) : ctrl_dur;
            end else begin
                dur_cnt_q <= '0;
            end
        end else if (delay_cnt_q != '0) begin
            delay_cnt_q <= delay_cnt_q - DLY_W'(1);
            if (delay_cnt_q == DLY_W'(1)) begin
                debug_req_o <= value_q;
            end
        end else if (dur_cnt_q != '0) begin
            dur_cnt_q <= dur_cnt_q - DUR_W'(1);
            // end of pulse restores the opposite level
            if (dur_cnt_q == DUR_W'(1)) begin
                debug_req_o <= ~value_q;
            end
        end
    end

endmodule

// File: hdl/irq_timer.sv
`timescale 1ns/1ps

module irq_timer #(
    parameter int IRQ_WIDTH = 32
) (
    input  logic                 clk_i,
    input  logic                 rst_ni,
    input  logic [4:0]           irq_id_i,
    input  logic                 irq_ack_i,
    periph_wr_if.timer           wr,
    output logic [IRQ_WIDTH-1:0] irq_o
);

    localparam int DW = mm_periph_pkg::DATA_W;

    logic [IRQ_WIDTH-1:0] mask_q;
    logic [DW-1:0]        cnt_q;
    logic [IRQ_WIDTH-1:0] irq_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            mask_q <= '0;
            cnt_q  <= '0;
            irq_q  <= '0;
        end else begin
            if (wr.timer_mask_we) begin
                mask_q <= wr.wdata[IRQ_WIDTH-1:0];
            end

            // a load of zero parks the counter
            if (wr.timer_count_we) begin
                cnt_q <= wr.wdata;
            end else if (cnt_q != '0) begin
                cnt_q <= cnt_q - DW'(1);
            end

            // expiry wins over a same-cycle acknowledge
            if (cnt_q == DW'(1)) begin
                irq_q <= mask_q;
            end else if (irq_ack_i) begin
                irq_q[irq_id_i] <= 1'b0;
            end
        end
    end

    assign irq_o = irq_q;

endmodule

// File: hdl/mm_periph_decoder.sv
`timescale 1ns/1ps

module mm_periph_decoder (
    input  logic                             clk_i,
    input  logic                             rst_ni,
    input  logic                             data_req_i,
    input  logic [mm_periph_pkg::DATA_W-1:0] data_addr_i,
    input  logic                             data_we_i,
    input  logic [mm_periph_pkg::DATA_W-1:0] data_wdata_i,
    output logic                             data_gnt_o,
    output logic                             data_rvalid_o,
    output logic [mm_periph_pkg::DATA_W-1:0] data_rdata_o,
    output logic                             tests_passed_o,
    output logic                             tests_failed_o,
    output logic                             exit_valid_o,
    output logic [mm_periph_pkg::DATA_W-1:0] exit_value_o,
    periph_wr_if.decoder                     wr
);

    logic                             wr_acc;
    logic                             rd_acc;
    logic                             tick_clr;
    logic [mm_periph_pkg::DATA_W-1:0] tick_cnt_q;
    logic                             tick_ovf_q;
    logic                             rvalid_q;
    logic [mm_periph_pkg::DATA_W-1:0] rdata_q;

    // no stalls, every request is granted in its own cycle
    assign data_gnt_o = data_req_i;
    assign wr_acc     = data_req_i & data_gnt_o & data_we_i;
    assign rd_acc     = data_req_i & data_gnt_o & ~data_we_i;

    // --------------------------------------------------
    // write decode
    // --------------------------------------------------

    always_comb begin
        wr.timer_mask_we  = 1'b0;
        wr.timer_count_we = 1'b0;
        wr.debug_we       = 1'b0;
        tests_passed_o    = 1'b0;
        tests_failed_o    = 1'b0;
        exit_valid_o      = 1'b0;
        tick_clr          = 1'b0;
        if (wr_acc) begin
            case (data_addr_i)
                mm_periph_pkg::ADDR_TEST_STATUS: begin
                    // other status values are silently dropped
                    tests_passed_o = (data_wdata_i == mm_periph_pkg::STATUS_PASS_CODE);
                    tests_failed_o = (data_wdata_i == mm_periph_pkg::STATUS_FAIL_CODE);
                end
                mm_periph_pkg::ADDR_EXIT:        exit_valid_o      = 1'b1;
                mm_periph_pkg::ADDR_TIMER_MASK:  wr.timer_mask_we  = 1'b1;
                mm_periph_pkg::ADDR_TIMER_COUNT: wr.timer_count_we = 1'b1;
                mm_periph_pkg::ADDR_DEBUG_CTRL:  wr.debug_we       = 1'b1;
                mm_periph_pkg::ADDR_TICKS:       tick_clr          = 1'b1;
                default: ;
            endcase
        end
    end

    assign wr.wdata     = data_wdata_i;
    assign exit_value_o = exit_valid_o ? data_wdata_i : '0;

    // --------------------------------------------------
    // cycle tick counter
    // --------------------------------------------------

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            tick_cnt_q <= '0;
            tick_ovf_q <= 1'b0;
        end else begin
            if (tick_clr) begin
                tick_cnt_q <= '0;
            end else begin
                tick_cnt_q <= tick_cnt_q + 1'b1;
            end
            // sticky, only reset clears it
            if (&tick_cnt_q && !tick_clr) begin
                tick_ovf_q <= 1'b1;
            end
        end
    end

    // --------------------------------------------------
    // read response, one cycle after the request
    // --------------------------------------------------

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rvalid_q <= 1'b0;
        end else begin
            rvalid_q <= rd_acc;
        end
    end

    // count as held before the read edge, unmapped reads give zero
    always_ff @(posedge clk_i) begin
        if (rd_acc) begin
            rdata_q <= (data_addr_i == mm_periph_pkg::ADDR_TICKS) ? tick_cnt_q : '0;
        end
    end

    assign data_rvalid_o = rvalid_q;
    assign data_rdata_o  = rdata_q;

endmodule

// File: hdl/mm_periph_pkg.sv
package mm_periph_pkg;

    // data bus width shared by all blocks
    localparam int DATA_W = 32;

    // --------------------------------------------------
    // memory-mapped addresses
    // --------------------------------------------------

    // test status and exit
    localparam logic [DATA_W-1:0] ADDR_TEST_STATUS = 32'h2000_0000;
    localparam logic [DATA_W-1:0] ADDR_EXIT        = 32'h2000_0004;

    // interrupt timer
    localparam logic [DATA_W-1:0] ADDR_TIMER_MASK  = 32'h1500_0000;
    localparam logic [DATA_W-1:0] ADDR_TIMER_COUNT = 32'h1500_0004;

    // debug request control word
    localparam logic [DATA_W-1:0] ADDR_DEBUG_CTRL  = 32'h1500_0008;

    // write clears, read returns the cycle count
    localparam logic [DATA_W-1:0] ADDR_TICKS       = 32'h1500_1004;

    // --------------------------------------------------
    // status codes
    // --------------------------------------------------

    localparam logic [DATA_W-1:0] STATUS_PASS_CODE = 32'd123456789;
    localparam logic [DATA_W-1:0] STATUS_FAIL_CODE = 32'd1;

    // --------------------------------------------------
    // debug control word layout
    // --------------------------------------------------

    // bit 29 and bit 15 are left over and not decoded
    localparam int DBG_VALUE_BIT = 31;
    localparam int DBG_PULSE_BIT = 30;
    localparam int DBG_DUR_LSB   = 16;
    localparam int DBG_DUR_W     = 13;
    localparam int DBG_DELAY_LSB = 0;
    localparam int DBG_DELAY_W   = 15;

endpackage

// File: hdl/mm_periph_top.sv
`timescale 1ns/1ps

module mm_periph_top #(
    parameter int IRQ_WIDTH = 32
) (
    input  logic                             clk_i,
    input  logic                             rst_ni,
    input  logic                             data_req_i,
    input  logic [mm_periph_pkg::DATA_W-1:0] data_addr_i,
    input  logic                             data_we_i,
    input  logic [mm_periph_pkg::DATA_W-1:0] data_wdata_i,
    input  logic [4:0]                       irq_id_i,
    input  logic                             irq_ack_i,
    output logic                             data_gnt_o,
    output logic                             data_rvalid_o,
    output logic [mm_periph_pkg::DATA_W-1:0] data_rdata_o,
    output logic [IRQ_WIDTH-1:0]             irq_o,
    output logic                             debug_req_o,
    output logic                             tests_passed_o,
    output logic                             tests_failed_o,
    output logic                             exit_valid_o,
    output logic [mm_periph_pkg::DATA_W-1:0] exit_value_o
);

    // decoded write strobes to the timer and debug units
    periph_wr_if wr_bus ();

    mm_periph_decoder decoder_inst (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .data_req_i     (data_req_i),
        .data_addr_i    (data_addr_i),
        .data_we_i      (data_we_i),
        .data_wdata_i   (data_wdata_i),
        .data_gnt_o     (data_gnt_o),
        .data_rvalid_o  (data_rvalid_o),
        .data_rdata_o   (data_rdata_o),
        .tests_passed_o (tests_passed_o),
        .tests_failed_o (tests_failed_o),
        .exit_valid_o   (exit_valid_o),
        .exit_value_o   (exit_value_o),
        .wr             (wr_bus.decoder)
    );

    irq_timer #(
        .IRQ_WIDTH (IRQ_WIDTH)
    ) irq_timer_inst (
        .clk_i     (clk_i),
        .rst_ni    (rst_ni),
        .irq_id_i  (irq_id_i),
        .irq_ack_i (irq_ack_i),
        .wr        (wr_bus.timer),
        .irq_o     (irq_o)
    );

    debug_req_gen debug_gen_inst (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .wr          (wr_bus.debug),
        .debug_req_o (debug_req_o)
    );

endmodule

// File: hdl/periph_wr_if.sv
`timescale 1ns/1ps

interface periph_wr_if;

    // single-cycle strobes, one per mapped unit register
    logic                             timer_mask_we;
    logic                             timer_count_we;
    logic                             debug_we;

    // write data, valid while a strobe is high
    logic [mm_periph_pkg::DATA_W-1:0] wdata;

    modport decoder (
        output timer_mask_we,
        output timer_count_we,
        output debug_we,
        output wdata
    );

    modport timer (input timer_mask_we, input timer_count_we, input wdata);

    modport debug (input debug_we, input wdata);

endinterface

// File: tb.f
hdl/mm_periph_pkg.sv
hdl/periph_wr_if.sv
hdl/mm_periph_decoder.sv
hdl/irq_timer.sv
hdl/debug_req_gen.sv
hdl/mm_periph_top.sv
testbench/tb_clock_gen.sv
testbench/tb_checker.sv
testbench/mm_periph_properties.sv
testbench/tb_top.sv

// File: testbench/mm_periph_properties.sv
`timescale 1ns/1ps

module mm_periph_properties (
    input logic clk_i,
    input logic rst_ni,
    input logic data_req_i,
    input logic data_we_i,
    input logic rvalid_i,
    input logic passed_i,
    input logic failed_i,
    input logic tick_ovf_i
);

    int fail_count = 0;

    a_rvalid_after_read: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        (data_req_i && !data_we_i) |=> rvalid_i
    ) else begin
        $error("data_rvalid_o missing one cycle after an accepted read");
        fail_count++;
    end

    a_rvalid_only_after_read: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        !(data_req_i && !data_we_i) |=> !rvalid_i
    ) else begin
        $error("data_rvalid_o high without a read in the cycle before");
        fail_count++;
    end

    a_pass_fail_exclusive: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        !(passed_i && failed_i)
    ) else begin
        $error("tests_passed_o and tests_failed_o high together");
        fail_count++;
    end

    a_no_tick_overflow: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        !tick_ovf_i
    ) else begin
        $error("tick counter overflow flag set");
        fail_count++;
    end

endmodule

bind mm_periph_top mm_periph_properties props_inst (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .data_req_i (data_req_i),
    .data_we_i  (data_we_i),
    .rvalid_i   (data_rvalid_o),
    .passed_i   (tests_passed_o),
    .failed_i   (tests_failed_o),
    .tick_ovf_i (decoder_inst.tick_ovf_q)
);

// File: testbench/tb_checker.sv
`timescale 1ns/1ps

module tb_checker #(
    parameter int IRQ_WIDTH = 32
) (
    input  logic                 clk_i,
    input  logic                 rst_ni,
    input  logic                 data_req_i,
    input  logic [31:0]          data_addr_i,
    input  logic                 data_we_i,
    input  logic [31:0]          data_wdata_i,
    input  logic [4:0]           irq_id_i,
    input  logic                 irq_ack_i,
    input  logic [31:0]          exp_rdata_i,
    input  logic                 gnt_i,
    input  logic                 rvalid_i,
    input  logic [31:0]          rdata_i,
    input  logic [IRQ_WIDTH-1:0] irq_i,
    input  logic                 debug_req_i,
    input  logic                 passed_i,
    input  logic                 failed_i,
    input  logic                 exit_valid_i,
    input  logic [31:0]          exit_value_i,
    output int                   err_count_o,
    output int                   check_count_o
);

    logic                 wr;
    logic                 rd;
    int unsigned          edge_no;
    logic [31:0]          m_tick;
    logic                 m_rvalid;
    logic [31:0]          m_rdata;
    logic [31:0]          m_rdata_tbl;
    logic [IRQ_WIDTH-1:0] m_mask;
    logic [IRQ_WIDTH-1:0] m_irq;
    int unsigned          irq_edge;
    logic                 m_dbg;
    logic                 dbg_val;
    int unsigned          dbg_set_edge;
    int unsigned          dbg_clr_edge;
    int unsigned          dbg_busy_until;
    int unsigned          dly;
    int unsigned          dur;

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        check_count_o++;
        if (exp !== act) begin
            err_count_o++;
            $display("ERROR at %0t: %s expected %h, got %h", $time, name, exp, act);
        end
    endtask

    function automatic bit hit(input logic [31:0] addr);
        return wr && (data_addr_i == addr);
    endfunction

    always @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            err_count_o    = 0;
            check_count_o  = 0;
            edge_no        = 0;
            m_tick         = '0;
            m_rvalid       = 1'b0;
            m_rdata        = '0;
            m_rdata_tbl    = '0;
            m_mask         = '0;
            m_irq          = '0;
            irq_edge       = 0;
            m_dbg          = 1'b0;
            dbg_val        = 1'b0;
            dbg_set_edge   = 0;
            dbg_clr_edge   = 0;
            dbg_busy_until = 0;
        end else begin
            wr = data_req_i && data_we_i;
            rd = data_req_i && !data_we_i;

            // --------------------------------------------------
            // outputs of the current cycle
            // --------------------------------------------------
            check_value("data_gnt_o", 32'(data_req_i), 32'(gnt_i));
            check_value("tests_passed_o", 32'(hit(mm_periph_pkg::ADDR_TEST_STATUS)
                && data_wdata_i == mm_periph_pkg::STATUS_PASS_CODE), 32'(passed_i));
            check_value("tests_failed_o", 32'(hit(mm_periph_pkg::ADDR_TEST_STATUS)
                && data_wdata_i == mm_periph_pkg::STATUS_FAIL_CODE), 32'(failed_i));
            check_value("exit_valid_o", 32'(hit(mm_periph_pkg::ADDR_EXIT)),
                        32'(exit_valid_i));
            if (hit(mm_periph_pkg::ADDR_EXIT)) begin
                check_value("exit_value_o", data_wdata_i, exit_value_i);
            end

            // registered outputs, as left by the previous edge
            check_value("data_rvalid_o", 32'(m_rvalid), 32'(rvalid_i));
            if (m_rvalid) begin
                check_value("data_rdata_o", m_rdata, rdata_i);
                check_value("data_rdata_o (table)", m_rdata_tbl, rdata_i);
            end
            check_value("irq_o", 32'(m_irq), 32'(irq_i));
            check_value("debug_req_o", 32'(m_dbg), 32'(debug_req_i));

            // --------------------------------------------------
            // advance the model by one edge
            // --------------------------------------------------
            edge_no++;
            m_rvalid = rd;
            if (rd) begin
                m_rdata     = (data_addr_i == mm_periph_pkg::ADDR_TICKS) ? m_tick : '0;
                m_rdata_tbl = exp_rdata_i;
            end
            m_tick = hit(mm_periph_pkg::ADDR_TICKS) ? '0 : m_tick + 32'd1;

            // timer fires N edges after its count write
            if (irq_edge != 0 && edge_no == irq_edge) begin
                m_irq = m_mask;
            end else if (irq_ack_i) begin
                m_irq[irq_id_i] = 1'b0;
            end
            if (hit(mm_periph_pkg::ADDR_TIMER_MASK)) begin
                m_mask = data_wdata_i[IRQ_WIDTH-1:0];
            end
            if (hit(mm_periph_pkg::ADDR_TIMER_COUNT)) begin
                irq_edge = (data_wdata_i == 0) ? 0 : edge_no + data_wdata_i;
            end

            // debug request, scheduled by edge number
            if (edge_no == dbg_set_edge) begin
                m_dbg = dbg_val;
            end
            if (edge_no == dbg_clr_edge) begin
                m_dbg = ~dbg_val;
            end
            if (hit(mm_periph_pkg::ADDR_DEBUG_CTRL) && edge_no > dbg_busy_until) begin
                dly = (data_wdata_i >> mm_periph_pkg::DBG_DELAY_LSB)
                      & ((1 << mm_periph_pkg::DBG_DELAY_W) - 1);
                dur = (data_wdata_i >> mm_periph_pkg::DBG_DUR_LSB)
                      & ((1 << mm_periph_pkg::DBG_DUR_W) - 1);
                dly = (dly == 0) ? 1 : dly;
                dur = (dur == 0) ? 1 : dur;
                dbg_val      = data_wdata_i[mm_periph_pkg::DBG_VALUE_BIT];
                dbg_set_edge = edge_no + dly;
                if (data_wdata_i[mm_periph_pkg::DBG_PULSE_BIT]) begin
                    dbg_clr_edge   = edge_no + dly + dur;
                    dbg_busy_until = dbg_clr_edge;
                end else begin
                    dbg_clr_edge   = 0;
                    dbg_busy_until = dbg_set_edge;
                end
            end
        end
    end

endmodule

// File: testbench/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS  = 8,
    parameter int RST_CYCLES = 8
) (
    output logic clk_o,
    output logic rst_no
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    // release away from the rising edge
    initial begin
        rst_no = 1'b0;
        repeat (RST_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        rst_no = 1'b1;
    end

endmodule

// File: testbench/tb_top.sv
`timescale 1ns/1ps

module tb_top;

    localparam int IRQ_WIDTH = 32;
    localparam int MAX_ROWS  = 32;
    localparam int OP_WRITE  = 1;
    localparam int OP_READ   = 2;
    localparam int OP_ACK    = 3;

    logic                 clk_i;
    logic                 rst_ni;
    logic                 data_req_i;
    logic [31:0]          data_addr_i;
    logic                 data_we_i;
    logic [31:0]          data_wdata_i;
    logic [4:0]           irq_id_i;
    logic                 irq_ack_i;
    logic [31:0]          exp_rdata;
    logic                 data_gnt_o;
    logic                 data_rvalid_o;
    logic [31:0]          data_rdata_o;
    logic [IRQ_WIDTH-1:0] irq_o;
    logic                 debug_req_o;
    logic                 tests_passed_o;
    logic                 tests_failed_o;
    logic                 exit_valid_o;
    logic [31:0]          exit_value_o;
    int                   err_count;
    int                   check_count;
    int                   assert_fails;

    // stimulus table
    int          op_q   [MAX_ROWS];
    logic [31:0] addr_q [MAX_ROWS];
    logic [31:0] data_q [MAX_ROWS];
    int          wait_q [MAX_ROWS];
    logic [31:0] exp_q  [MAX_ROWS];
    int          n_rows;
    int          tick_gap;
    int          cycle_limit = 100000;
    int          cycle_cnt   = 0;
    logic [31:0] lfsr_state;
    logic [31:0] mask;
    int          n_cnt;
    int          d1;
    int          d2;
    int          w2;
    int          gap;
    logic [4:0]  ack_id;

    tb_clock_gen clock_gen_inst (
        .clk_o  (clk_i),
        .rst_no (rst_ni)
    );

    mm_periph_top #(
        .IRQ_WIDTH (IRQ_WIDTH)
    ) mm_periph_top_inst (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .data_req_i     (data_req_i),
        .data_addr_i    (data_addr_i),
        .data_we_i      (data_we_i),
        .data_wdata_i   (data_wdata_i),
        .irq_id_i       (irq_id_i),
        .irq_ack_i      (irq_ack_i),
        .data_gnt_o     (data_gnt_o),
        .data_rvalid_o  (data_rvalid_o),
        .data_rdata_o   (data_rdata_o),
        .irq_o          (irq_o),
        .debug_req_o    (debug_req_o),
        .tests_passed_o (tests_passed_o),
        .tests_failed_o (tests_failed_o),
        .exit_valid_o   (exit_valid_o),
        .exit_value_o   (exit_value_o)
    );

    tb_checker #(
        .IRQ_WIDTH (IRQ_WIDTH)
    ) checker_inst (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .data_req_i    (data_req_i),
        .data_addr_i   (data_addr_i),
        .data_we_i     (data_we_i),
        .data_wdata_i  (data_wdata_i),
        .irq_id_i      (irq_id_i),
        .irq_ack_i     (irq_ack_i),
        .exp_rdata_i   (exp_rdata),
        .gnt_i         (data_gnt_o),
        .rvalid_i      (data_rvalid_o),
        .rdata_i       (data_rdata_o),
        .irq_i         (irq_o),
        .debug_req_i   (debug_req_o),
        .passed_i      (tests_passed_o),
        .failed_i      (tests_failed_o),
        .exit_valid_i  (exit_valid_o),
        .exit_value_i  (exit_value_o),
        .err_count_o   (err_count),
        .check_count_o (check_count)
    );

    // --------------------------------------------------
    // galois lfsr random source stepped once per bit
    // --------------------------------------------------

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            r = {r[30:0], lfsr_state[0]};
        end
        return r;
    endfunction

    function automatic logic [31:0] debug_word(input bit value, input bit pulse,
                                               input int dur, input int delay);
        return (32'(value) << mm_periph_pkg::DBG_VALUE_BIT)
             | (32'(pulse) << mm_periph_pkg::DBG_PULSE_BIT)
             | (32'(dur) << mm_periph_pkg::DBG_DUR_LSB)
             | (32'(delay) << mm_periph_pkg::DBG_DELAY_LSB);
    endfunction

    // tick reads expect one less than the cycles since the last clear
    task automatic add_row(input int op, input logic [31:0] addr,
                           input logic [31:0] data, input int w);
        exp_q[n_rows] = '0;
        if (op == OP_READ && addr == mm_periph_pkg::ADDR_TICKS) begin
            exp_q[n_rows] = 32'(tick_gap - 1);
        end
        if (op == OP_WRITE && addr == mm_periph_pkg::ADDR_TICKS) begin
            tick_gap = 0;
        end
        op_q[n_rows]   = op;
        addr_q[n_rows] = addr;
        data_q[n_rows] = data;
        wait_q[n_rows] = w;
        tick_gap += 1 + w;
        n_rows++;
    endtask

    task automatic idle_inputs();
        data_req_i   = 1'b0;
        data_addr_i  = '0;
        data_we_i    = 1'b0;
        data_wdata_i = '0;
        irq_id_i     = '0;
        irq_ack_i    = 1'b0;
        exp_rdata    = '0;
    endtask

    task automatic apply_row(input int i);
        idle_inputs();
        if (op_q[i] == OP_ACK) begin
            irq_ack_i = 1'b1;
            irq_id_i  = data_q[i][4:0];
        end else begin
            data_req_i   = 1'b1;
            data_we_i    = (op_q[i] == OP_WRITE);
            data_addr_i  = addr_q[i];
            data_wdata_i = data_q[i];
            exp_rdata    = exp_q[i];
        end
    endtask

    initial begin
        idle_inputs();
        lfsr_state = 32'hd95972b6;
        n_rows     = 0;
        tick_gap   = 0;
        mask   = rand_bits(32);
        n_cnt  = 1 + int'(rand_bits(5)) % 20;
        ack_id = 5'(rand_bits(5));
        // both acknowledged bits set so that each clear is visible
        mask   = mask | (32'd1 << ack_id) | (32'd1 << (ack_id ^ 5'd1));
        d1     = 1 + int'(rand_bits(4)) % 10;
        d2     = 1 + int'(rand_bits(4)) % 10;
        w2     = 1 + int'(rand_bits(4)) % 10;
        gap    = 1 + int'(rand_bits(4)) % 10;

        add_row(OP_WRITE, mm_periph_pkg::ADDR_TICKS, 32'd0, 2);
        add_row(OP_WRITE, mm_periph_pkg::ADDR_TEST_STATUS, mm_periph_pkg::STATUS_PASS_CODE, 1);
        add_row(OP_WRITE, mm_periph_pkg::ADDR_TEST_STATUS, mm_periph_pkg::STATUS_FAIL_CODE, 1);
        add_row(OP_WRITE, mm_periph_pkg::ADDR_TEST_STATUS, 32'd42, 1);
        add_row(OP_WRITE, mm_periph_pkg::ADDR_EXIT, 32'h0000_005a, 1);
        add_row(OP_WRITE, mm_periph_pkg::ADDR_TIMER_MASK, mask, 1);
        add_row(OP_WRITE, mm_periph_pkg::ADDR_TIMER_COUNT, 32'(n_cnt), n_cnt + 2);
        add_row(OP_ACK, 32'd0, 32'(ack_id), 1);
        add_row(OP_ACK, 32'd0, 32'(ack_id ^ 5'd1), 1);
        // second write lands while the first delay still counts
        add_row(OP_WRITE, mm_periph_pkg::ADDR_DEBUG_CTRL, debug_word(1, 0, 0, d1), 0);
        add_row(OP_WRITE, mm_periph_pkg::ADDR_DEBUG_CTRL, debug_word(0, 0, 0, 1), d1 + 3);
        add_row(OP_WRITE, mm_periph_pkg::ADDR_DEBUG_CTRL, debug_word(0, 0, 0, 0), 3);
        add_row(OP_WRITE, mm_periph_pkg::ADDR_DEBUG_CTRL, debug_word(1, 1, w2, d2),
                d2 + w2 + 3);
        add_row(OP_WRITE, mm_periph_pkg::ADDR_TICKS, 32'd0, gap);
        add_row(OP_READ, mm_periph_pkg::ADDR_TICKS, 32'd0, 3);
        add_row(OP_READ, mm_periph_pkg::ADDR_TICKS, 32'd0, 0);
        add_row(OP_READ, mm_periph_pkg::ADDR_TICKS, 32'd0, 1);
        add_row(OP_READ, 32'h1500_0100, 32'd0, 2);

        cycle_limit = 200;
        for (int i = 0; i < n_rows; i++) begin
            cycle_limit += 1 + wait_q[i];
        end

        wait (rst_ni === 1'b1);
        @(negedge clk_i);
        for (int i = 0; i < n_rows; i++) begin
            apply_row(i);
            @(negedge clk_i);
            idle_inputs();
            repeat (wait_q[i]) @(negedge clk_i);
        end
        repeat (4) @(negedge clk_i);

        assert_fails = mm_periph_top_inst.props_inst.fail_count;
        $display("checks: %0d, errors: %0d, assertion failures: %0d",
                 check_count, err_count, assert_fails);
        if (err_count == 0 && assert_fails == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // guard against a stuck stimulus loop
    always @(posedge clk_i) begin
        cycle_cnt++;
        if (cycle_cnt >= cycle_limit) begin
            $display("timeout: stimulus did not finish within %0d cycles", cycle_limit);
            $display("TEST FAILED");
            $finish;
        end
    end

endmodule
